/* source/axiPkg.sv */
package axiPkg;

  // bus widths
  typedef logic [31:0] addrT;
  typedef logic [31:0] dataT;
  typedef logic [3:0]  strbT;
  typedef logic [1:0]  respT;

  localparam respT RESP_OKAY   = 2'd0;
  localparam respT RESP_SLVERR = 2'd2;

  // per-direction grant machine of the arbiter
  typedef enum logic [1:0] {
    IDLE,
    ADDR,  // request channels routed to the slave
    RESP   // waiting for the response handshake
  } arbState;

endpackage

/* source/axiLiteIf.sv */
interface axiLiteIf;
  import axiPkg::*;

  addrT araddr;
  logic arvalid;
  logic arready;

  dataT rdata;
  respT rresp;
  logic rvalid;
  logic rready;

  addrT awaddr;
  logic awvalid;
  logic awready;

  dataT wdata;
  strbT wstrb;
  logic wvalid;
  logic wready;

  respT bresp;
  logic bvalid;
  logic bready;

  modport master (
    output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

  modport slave (
    input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
  );

endinterface

/* source/axiArbiter.sv */
module axiArbiter (
  input  logic         clk,
  input  logic         rst,
  // master A, instruction fetch
  input  axiPkg::addrT araddrA,
  input  logic         arvalidA,
  output logic         arreadyA,
  output axiPkg::dataT rdataA,
  output axiPkg::respT rrespA,
  output logic         rvalidA,
  input  logic         rreadyA,
  input  axiPkg::addrT awaddrA,
  input  logic         awvalidA,
  output logic         awreadyA,
  input  axiPkg::dataT wdataA,
  input  axiPkg::strbT wstrbA,
  input  logic         wvalidA,
  output logic         wreadyA,
  output logic         bvalidA,
  output axiPkg::respT brespA,
  input  logic         breadyA,
  // master B, load/store
  input  axiPkg::addrT araddrB,
  input  logic         arvalidB,
  output logic         arreadyB,
  output axiPkg::dataT rdataB,
  output axiPkg::respT rrespB,
  output logic         rvalidB,
  input  logic         rreadyB,
  input  axiPkg::addrT awaddrB,
  input  logic         awvalidB,
  output logic         awreadyB,
  input  axiPkg::dataT wdataB,
  input  axiPkg::strbT wstrbB,
  input  logic         wvalidB,
  output logic         wreadyB,
  output logic         bvalidB,
  output axiPkg::respT brespB,
  input  logic         breadyB,
  axiLiteIf.master     sbus
);
  import axiPkg::*;

  arbState rdState, wrState;
  logic    rdOwnB, wrOwnB;  // high when B owns
  logic    awDone, wDone;   // write beats already passed to the slave
  logic    arHs, rHs, awHs, wHs, bHs;
  logic    arSelA, arSelB, rSelA, rSelB;
  logic    awSelA, awSelB, wSelA, wSelB, bSelA, bSelB;

  assign arHs = sbus.arvalid && sbus.arready;
  assign rHs  = sbus.rvalid && sbus.rready;
  assign awHs = sbus.awvalid && sbus.awready;
  assign wHs  = sbus.wvalid && sbus.wready;
  assign bHs  = sbus.bvalid && sbus.bready;

  // read grant where A wins a tie
  always_ff @(posedge clk) begin
    if (rst) begin
      rdState <= IDLE;
      rdOwnB  <= 1'b0;
    end else begin
      case (rdState)
        IDLE: if (arvalidA || arvalidB) begin
          rdState <= ADDR;
          rdOwnB  <= !arvalidA;
        end
        ADDR: if (arHs) rdState <= RESP;
        RESP: if (rHs) rdState <= IDLE;
        default: rdState <= IDLE;
      endcase
    end
  end

  // write grant held through the b handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      wrState <= IDLE;
      wrOwnB  <= 1'b0;
      awDone  <= 1'b0;
      wDone   <= 1'b0;
    end else begin
      case (wrState)
        IDLE: if (awvalidA || awvalidB) begin
          wrState <= ADDR;
          wrOwnB  <= !awvalidA;
          awDone  <= 1'b0;
          wDone   <= 1'b0;
        end
        ADDR: begin
          if (awHs) awDone <= 1'b1;
          if (wHs) wDone <= 1'b1;
          if ((awDone || awHs) && (wDone || wHs)) wrState <= RESP;
        end
        RESP: if (bHs) wrState <= IDLE;
        default: wrState <= IDLE;
      endcase
    end
  end

  assign arSelA = (rdState == ADDR) && !rdOwnB;
  assign arSelB = (rdState == ADDR) && rdOwnB;
  assign rSelA  = (rdState == RESP) && !rdOwnB;
  assign rSelB  = (rdState == RESP) && rdOwnB;
  assign awSelA = (wrState == ADDR) && !wrOwnB && !awDone;
  assign awSelB = (wrState == ADDR) && wrOwnB && !awDone;
  assign wSelA  = (wrState == ADDR) && !wrOwnB && !wDone;
  assign wSelB  = (wrState == ADDR) && wrOwnB && !wDone;
  assign bSelA  = (wrState == RESP) && !wrOwnB;
  assign bSelB  = (wrState == RESP) && wrOwnB;

  // requests from the owner to the slave
  assign sbus.araddr  = rdOwnB ? araddrB : araddrA;
  assign sbus.arvalid = (arSelA && arvalidA) || (arSelB && arvalidB);
  assign sbus.rready  = (rSelA && rreadyA) || (rSelB && rreadyB);
  assign sbus.awaddr  = wrOwnB ? awaddrB : awaddrA;
  assign sbus.awvalid = (awSelA && awvalidA) || (awSelB && awvalidB);
  assign sbus.wdata   = wrOwnB ? wdataB : wdataA;
  assign sbus.wstrb   = wrOwnB ? wstrbB : wstrbA;
  assign sbus.wvalid  = (wSelA && wvalidA) || (wSelB && wvalidB);
  assign sbus.bready  = (bSelA && breadyA) || (bSelB && breadyB);

  // responses back to the owner only
  assign arreadyA = arSelA && sbus.arready;
  assign arreadyB = arSelB && sbus.arready;
  assign rvalidA  = rSelA && sbus.rvalid;
  assign rvalidB  = rSelB && sbus.rvalid;
  assign rdataA   = rSelA ? sbus.rdata : '0;
  assign rdataB   = rSelB ? sbus.rdata : '0;
  assign rrespA   = rSelA ? sbus.rresp : RESP_OKAY;
  assign rrespB   = rSelB ? sbus.rresp : RESP_OKAY;
  assign awreadyA = awSelA && sbus.awready;
  assign awreadyB = awSelB && sbus.awready;
  assign wreadyA  = wSelA && sbus.wready;
  assign wreadyB  = wSelB && sbus.wready;
  assign bvalidA  = bSelA && sbus.bvalid;
  assign bvalidB  = bSelB && sbus.bvalid;
  assign brespA   = bSelA ? sbus.bresp : RESP_OKAY;
  assign brespB   = bSelB ? sbus.bresp : RESP_OKAY;

  // slave must not answer a read nobody asked for
  aRdIdleQuiet: assert property (@(posedge clk) disable iff (rst)
    rdState == IDLE |-> !sbus.rvalid)
    else $error("sbus.rvalid high while read side is idle");

  // the owner keeps its request up until the slave takes it
  aRdOwnerReq: assert property (@(posedge clk) disable iff (rst)
    rdState == ADDR |-> sbus.arvalid)
    else $error("read granted to a master with no pending request");

  aWrOwnerReq: assert property (@(posedge clk) disable iff (rst)
    wrState == ADDR && !awDone |-> sbus.awvalid)
    else $error("write granted to a master with no pending request");

endmodule

/* source/axiSram.sv */
module axiSram #(
  parameter int MEM_WORDS    = 1024,
  parameter int READ_LATENCY = 2
) (
  input  logic    clk,
  input  logic    rst,
  axiLiteIf.slave sbus
);
  import axiPkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = $clog2(READ_LATENCY + 1);

  typedef logic [IDX_W-1:0] wordIdxT;

  dataT mem [MEM_WORDS];

  logic             rdPending, rvalidQ;
  logic [CNT_W-1:0] rdCnt;
  addrT             rdAddr, rdSrcAddr;
  dataT             rdataQ;
  respT             rrespQ;
  logic             arHs, rHs, rdFire, rdInRange;

  logic awHeld, wHeld, bvalidQ;
  addrT wrAddr;
  dataT wrData;
  strbT wrStrb;
  respT brespQ;
  logic awHs, wHs, bHs, wrApply, wrInRange;

  if (READ_LATENCY < 1) begin : gLatencyCheck
    $error("axiSram: READ_LATENCY must be at least 1");
  end

  assign arHs = sbus.arvalid && sbus.arready;
  assign rHs  = sbus.rvalid && sbus.rready;

  // latency 1 answers straight from the bus address
  assign rdFire    = (arHs && READ_LATENCY == 1) || (rdCnt == CNT_W'(1));
  assign rdSrcAddr = (READ_LATENCY == 1) ? sbus.araddr : rdAddr;
  assign rdInRange = rdSrcAddr[31:2] < 30'(MEM_WORDS);

  always_ff @(posedge clk) begin
    if (rst) begin
      rdPending <= 1'b0;
      rvalidQ   <= 1'b0;
      rdCnt     <= '0;
    end else begin
      if (arHs) begin
        rdPending <= 1'b1;
        rdCnt     <= CNT_W'(READ_LATENCY - 1);
      end else if (rdCnt != '0) begin
        rdCnt <= rdCnt - 1'b1;
      end
      if (rdFire) begin
        rvalidQ <= 1'b1;
      end else if (rHs) begin
        rvalidQ   <= 1'b0;
        rdPending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arHs) rdAddr <= sbus.araddr;
    if (rdFire) begin
      rdataQ <= rdInRange ? mem[wordIdxT'(rdSrcAddr[31:2])] : '0;
      rrespQ <= rdInRange ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign sbus.arready = !rdPending;
  assign sbus.rvalid  = rvalidQ;
  assign sbus.rdata   = rdataQ;
  assign sbus.rresp   = rrespQ;

  // aw and w captured independently
  assign awHs      = sbus.awvalid && sbus.awready;
  assign wHs       = sbus.wvalid && sbus.wready;
  assign bHs       = sbus.bvalid && sbus.bready;
  assign wrApply   = awHeld && wHeld && !bvalidQ;
  assign wrInRange = wrAddr[31:2] < 30'(MEM_WORDS);

  always_ff @(posedge clk) begin
    if (rst) begin
      awHeld  <= 1'b0;
      wHeld   <= 1'b0;
      bvalidQ <= 1'b0;
    end else begin
      if (awHs) awHeld <= 1'b1;
      if (wHs) wHeld <= 1'b1;
      if (wrApply) begin
        bvalidQ <= 1'b1;
      end else if (bHs) begin
        bvalidQ <= 1'b0;
        awHeld  <= 1'b0;
        wHeld   <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awHs) wrAddr <= sbus.awaddr;
    if (wHs) begin
      wrData <= sbus.wdata;
      wrStrb <= sbus.wstrb;
    end
    if (wrApply) begin
      brespQ <= wrInRange ? RESP_OKAY : RESP_SLVERR;
      if (wrInRange) begin
        for (int i = 0; i < $bits(strbT); i++) begin
          if (wrStrb[i]) mem[wordIdxT'(wrAddr[31:2])][8*i +: 8] <= wrData[8*i +: 8];
        end
      end
    end
  end

  assign sbus.awready = !awHeld;
  assign sbus.wready  = !wHeld;
  assign sbus.bvalid  = bvalidQ;
  assign sbus.bresp   = brespQ;

  aRdataHold: assert property (@(posedge clk) disable iff (rst)
    sbus.rvalid && !sbus.rready |=> sbus.rvalid && $stable(sbus.rdata) && $stable(sbus.rresp))
    else $error("read response changed under back-pressure");

endmodule

/* source/memSubsystem.sv */
module memSubsystem #(
  parameter int MEM_WORDS    = 1024,
  parameter int READ_LATENCY = 2
) (
  input  logic         clk,
  input  logic         rst,
  // master A
  input  axiPkg::addrT araddrA,
  input  logic         arvalidA,
  output logic         arreadyA,
  output axiPkg::dataT rdataA,
  output axiPkg::respT rrespA,
  output logic         rvalidA,
  input  logic         rreadyA,
  input  axiPkg::addrT awaddrA,
  input  logic         awvalidA,
  output logic         awreadyA,
  input  axiPkg::dataT wdataA,
  input  axiPkg::strbT wstrbA,
  input  logic         wvalidA,
  output logic         wreadyA,
  output logic         bvalidA,
  output axiPkg::respT brespA,
  input  logic         breadyA,
  // master B
  input  axiPkg::addrT araddrB,
  input  logic         arvalidB,
  output logic         arreadyB,
  output axiPkg::dataT rdataB,
  output axiPkg::respT rrespB,
  output logic         rvalidB,
  input  logic         rreadyB,
  input  axiPkg::addrT awaddrB,
  input  logic         awvalidB,
  output logic         awreadyB,
  input  axiPkg::dataT wdataB,
  input  axiPkg::strbT wstrbB,
  input  logic         wvalidB,
  output logic         wreadyB,
  output logic         bvalidB,
  output axiPkg::respT brespB,
  input  logic         breadyB
);

  axiLiteIf bus0 ();

  // master ports share names with the arbiter
  axiArbiter arb0 (
    .sbus(bus0.master),
    .*
  );

  axiSram #(
    .MEM_WORDS   (MEM_WORDS),
    .READ_LATENCY(READ_LATENCY)
  ) sram0 (
    .clk (clk),
    .rst (rst),
    .sbus(bus0.slave)
  );

endmodule

/* tb/tbMemSubsystem.sv */
module tbMemSubsystem;
  timeunit 1ns;
  timeprecision 100ps;
  import axiPkg::*;

  localparam int MEM_WORDS    = 1024;
  localparam int READ_LATENCY = 2;
  localparam int IDX_W        = $clog2(MEM_WORDS);
  localparam bit MA           = 1'b0;  // fetch port
  localparam bit MB           = 1'b1;  // load/store port

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic [1:0] arvalid, arready, rvalid, rready, awvalid, awready;
  logic [1:0] wvalid, wready, bvalid, bready;
  addrT araddr [2];
  addrT awaddr [2];
  dataT rdata [2];
  dataT wdata [2];
  strbT wstrb [2];
  respT rresp [2];
  respT bresp [2];

  dataT expRdata [2];
  respT expRresp [2];
  respT expBresp [2];
  dataT shadow [MEM_WORDS];  // reference copy of the SRAM
  logic [1:0] rdBusy;
  logic raceMode;
  logic [31:0] lfsr = 32'h4813_015b;
  int valueErrs = 0;
  int protoErrs = 0;
  int cycles = 0;
  int txIssued = 0;
  arbState rdSt, wrSt;

  memSubsystem #(
    .MEM_WORDS   (MEM_WORDS),
    .READ_LATENCY(READ_LATENCY)
  ) dut0 (
    .clk(clk), .rst(rst),
    .araddrA(araddr[0]), .araddrB(araddr[1]),
    .arvalidA(arvalid[0]), .arvalidB(arvalid[1]),
    .arreadyA(arready[0]), .arreadyB(arready[1]),
    .rdataA(rdata[0]), .rdataB(rdata[1]),
    .rrespA(rresp[0]), .rrespB(rresp[1]),
    .rvalidA(rvalid[0]), .rvalidB(rvalid[1]),
    .rreadyA(rready[0]), .rreadyB(rready[1]),
    .awaddrA(awaddr[0]), .awaddrB(awaddr[1]),
    .awvalidA(awvalid[0]), .awvalidB(awvalid[1]),
    .awreadyA(awready[0]), .awreadyB(awready[1]),
    .wdataA(wdata[0]), .wdataB(wdata[1]),
    .wstrbA(wstrb[0]), .wstrbB(wstrb[1]),
    .wvalidA(wvalid[0]), .wvalidB(wvalid[1]),
    .wreadyA(wready[0]), .wreadyB(wready[1]),
    .bvalidA(bvalid[0]), .bvalidB(bvalid[1]),
    .brespA(bresp[0]), .brespB(bresp[1]),
    .breadyA(bready[0]), .breadyB(bready[1])
  );

  assign rdSt = dut0.arb0.rdState;
  assign wrSt = dut0.arb0.wrState;

  always #5 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic randBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], randBit()};
    return v;
  endfunction

  function automatic bit inRange(input addrT addr);
    return addr < addrT'(MEM_WORDS * 4);
  endfunction

  task automatic valueError(input string name, input bit m, input logic [31:0] exp,
                            input logic [31:0] got);
    valueErrs++;
    $display("ERR %s%s exp 0x%h got 0x%h", name, m ? "B" : "A", exp, got);
  endtask

  task automatic protocolError(input string msg);
    protoErrs++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic readWord(input bit m, input addrT addr);
    logic done;
    logic [IDX_W-1:0] idx;
    idx = addr[IDX_W+1:2];
    done = 1'b0;
    @(posedge clk);
    txIssued++;
    rdBusy[m] <= 1'b1;
    if (inRange(addr)) begin
      expRdata[m] <= shadow[idx];
      expRresp[m] <= RESP_OKAY;
    end else begin
      expRdata[m] <= '0;
      expRresp[m] <= RESP_SLVERR;
    end
    araddr[m]  <= addr;
    arvalid[m] <= 1'b1;
    rready[m]  <= randBit();
    while (!done) begin
      @(posedge clk);
      if (arvalid[m] && arready[m]) arvalid[m] <= 1'b0;
      done = rvalid[m] && rready[m];
      rready[m] <= done ? 1'b0 : randBit();  // random back-pressure
    end
    rdBusy[m] <= 1'b0;
  endtask

  task automatic writeWord(input bit m, input addrT addr, input dataT data, input strbT strb);
    logic done;
    logic [IDX_W-1:0] idx;
    idx = addr[IDX_W+1:2];
    done = 1'b0;
    @(posedge clk);
    txIssued++;
    expBresp[m] <= inRange(addr) ? RESP_OKAY : RESP_SLVERR;
    awaddr[m]  <= addr;
    awvalid[m] <= 1'b1;
    wdata[m]   <= data;
    wstrb[m]   <= strb;
    wvalid[m]  <= 1'b1;
    bready[m]  <= randBit();
    while (!done) begin
      @(posedge clk);
      if (awvalid[m] && awready[m]) awvalid[m] <= 1'b0;
      if (wvalid[m] && wready[m]) wvalid[m] <= 1'b0;
      done = bvalid[m] && bready[m];
      bready[m] <= done ? 1'b0 : randBit();
    end
    if (inRange(addr)) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) shadow[idx][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  task automatic closeRun(input bit timedOut);
    $display("errors: value %0d protocol %0d timeout %0d", valueErrs, protoErrs, timedOut);
    if (valueErrs == 0 && protoErrs == 0 && !timedOut) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  for (genvar m = 0; m < 2; m++) begin : gChk
    aRdata: assert property (@(posedge clk) disable iff (rst)
      rvalid[m] && rready[m] |-> rdata[m] == expRdata[m])
      else valueError("rdata", 1'(m), expRdata[m], rdata[m]);
    aRresp: assert property (@(posedge clk) disable iff (rst)
      rvalid[m] && rready[m] |-> rresp[m] == expRresp[m])
      else valueError("rresp", 1'(m), 32'(expRresp[m]), 32'(rresp[m]));
    aBresp: assert property (@(posedge clk) disable iff (rst)
      bvalid[m] && bready[m] |-> bresp[m] == expBresp[m])
      else valueError("bresp", 1'(m), 32'(expBresp[m]), 32'(bresp[m]));
    aRHold: assert property (@(posedge clk) disable iff (rst)
      rvalid[m] && !rready[m] |=> rvalid[m] && $stable(rdata[m]) && $stable(rresp[m]))
      else protocolError("read response dropped or changed while rready was low");
    aBHold: assert property (@(posedge clk) disable iff (rst)
      bvalid[m] && !bready[m] |=> bvalid[m] && $stable(bresp[m]))
      else protocolError("write response dropped or changed while bready was low");
    aRdOther: assert property (@(posedge clk) disable iff (rst)
      rdSt != IDLE && dut0.arb0.rdOwnB != 1'(m) |-> !(arready[m] || rvalid[m]))
      else protocolError($sformatf("ungranted master saw read handshake in %s", rdSt.name()));
    aWrOther: assert property (@(posedge clk) disable iff (rst)
      wrSt != IDLE && dut0.arb0.wrOwnB != 1'(m) |-> !(awready[m] || wready[m] || bvalid[m]))
      else protocolError($sformatf("ungranted master saw write handshake in %s", wrSt.name()));
  end

  // fixed priority, A answered first in a tie
  aTieOrder: assert property (@(posedge clk) disable iff (rst)
    raceMode && rvalid[1] |-> !rdBusy[0])
    else protocolError("master B got its read data before master A in a tie");

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > 40 * txIssued + 200) begin
      $display("timeout, a transaction never completed within %0d cycles", cycles);
      closeRun(1'b1);
    end
  end

  initial begin
    arvalid = '0;
    rready = '0;
    awvalid = '0;
    wvalid = '0;
    bready = '0;
    araddr = '{default: '0};
    awaddr = '{default: '0};
    wdata = '{default: '0};
    wstrb = '{default: '0};
    rdBusy = '0;
    raceMode = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    // full word, then a partial overwrite, then read back
    for (int i = 0; i < 4; i++) begin
      writeWord(MA, addrT'(4 * i), randBits(32), 4'hF);
      writeWord(MA, addrT'(4 * i), randBits(32), strbT'(randBits(4)));
      readWord(MA, addrT'(4 * i));
      writeWord(MB, addrT'(64 + 4 * i), randBits(32), 4'hF);
      writeWord(MB, addrT'(64 + 4 * i), randBits(32), strbT'(randBits(4)));
      readWord(MB, addrT'(64 + 4 * i));
    end

    raceMode <= 1'b1;
    fork
      readWord(MA, 32'h8);
      readWord(MB, 32'h44);
    join
    raceMode <= 1'b0;

    fork
      writeWord(MA, 32'hc, randBits(32), 4'hF);
      writeWord(MB, 32'h4c, randBits(32), 4'hF);
    join

    // read in flight while B writes elsewhere
    fork
      readWord(MA, 32'h4);
      writeWord(MB, 32'h48, randBits(32), 4'hF);
    join
    readWord(MA, 32'h48);
    readWord(MB, 32'h4);

    writeWord(MB, addrT'(MEM_WORDS * 4), 32'hdead_beef, 4'hF);
    readWord(MA, addrT'(MEM_WORDS * 4 + 8));
    readWord(MB, 32'h0);  // word 0 untouched by the rejected write
    repeat (4) @(posedge clk);
    closeRun(1'b0);
  end

endmodule

/* all.f */
source/axiPkg.sv
source/axiLiteIf.sv
source/axiArbiter.sv
source/axiSram.sv
source/memSubsystem.sv
tb/tbMemSubsystem.sv

/* Makefile */
TOP = tbMemSubsystem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
